/* keypad_text.f */
common/keypad_pkg.sv
keypad/keypad_scanner.sv
keypad/multitap_encoder.sv
design/key_position_display.sv
design/panel_driver.sv
design/keypad_text_top.sv
test/keypad_model.sv
test/keypad_text_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the keypad text testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module keypad_text_tb \
  --Mdir obj_dir -o keypad_text_sim \
  -f keypad_text.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/keypad_text_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit $sim_status
fi

exit 0

/* test/keypad_text_tb.sv */
module keypad_text_tb;
  import keypad_pkg::*;

  localparam int timeout_cycles = 4000;  // About 60 presses of 30 cycles, plus margin

  // Hex font of the board, a in bit 0, g in bit 6
  localparam logic [6:0] hex_font [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h67, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic        clk;
  logic        nRst;
  logic [3:0]  read_row;
  logic [3:0]  scan_col;
  logic [7:0]  ss0;
  logic [7:0]  ss1;
  logic [7:0]  ss2;
  logic [7:0]  ss3;
  logic        red;
  logic        green;
  logic        blue;
  logic        key_down;
  logic [7:0]  key_req;       // {row, col} requested from the keypad
  logic        col_hit;
  logic [34:0] panel;

  // Expected board state
  logic [7:0]  exp_letter;     // 0 while no letter is shown
  logic        exp_blue;
  int          exp_row;        // -1 until the first key
  int          exp_col;
  logic [34:0] exp_panel;
  logic        panel_check;    // Outputs have settled
  logic        submit_pending; // Letter submit in flight, blue may rise
  logic        clear_pending;  // Clear in flight, blue may fall
  string       test_name;
  int          taps;
  int          cycles = 0;

  assign panel = {red, green, blue, ss3, ss2, ss1, ss0};

  keypad_text_top uut (
    .clk      (clk),
    .nRst     (nRst),
    .read_row (read_row),
    .scan_col (scan_col),
    .ss0      (ss0),
    .ss1      (ss1),
    .ss2      (ss2),
    .ss3      (ss3),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  keypad_model keypad (
    .scan_col (scan_col),
    .key_down (key_down),
    .key_code (key_req),
    .read_row (read_row),
    .col_hit  (col_hit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Digits, colours and reset state
  a_reset: assert property (@(posedge clk) !nRst |-> (panel == 35'd0 && scan_col == 4'd0))
    else stop_with_error($sformatf("[ERROR] %s: reset panel expected %h, actual %h",
                                   test_name, 35'd0, $sampled(panel)));
  a_panel: assert property (@(posedge clk) disable iff (!nRst)
    panel_check |-> (panel == exp_panel))
    else stop_with_error($sformatf("[ERROR] %s: panel expected %h, actual %h",
                                   test_name, exp_panel, $sampled(panel)));
  a_blue_rise: assert property (@(posedge clk) disable iff (!nRst)
    $rose(blue) |-> (submit_pending && $past(uut.letter_ready)))
    else stop_with_error($sformatf("[ERROR] %s: blue expected %b, actual %b, no letter submitted",
                                   test_name, 1'b0, 1'b1));
  a_blue_fall: assert property (@(posedge clk) disable iff (!nRst)
    $fell(blue) |-> clear_pending)
    else stop_with_error($sformatf("[ERROR] %s: blue expected %b, actual %b, no clear pressed",
                                   test_name, 1'b1, 1'b0));

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles)
      stop_with_error($sformatf("Timeout: test did not finish within %0d cycles", cycles));
  end

  // Whole panel from the expected letter, blue and last key
  function automatic logic [34:0] expect_panel();
    logic       no_key;
    logic [7:0] dig_row;
    logic [7:0] dig_col;
    logic [7:0] dig_hi;
    logic [7:0] dig_lo;
    no_key  = (exp_row < 0);
    dig_row = no_key ? {1'b0, seg_blank} : {1'b0, hex_font[exp_row[3:0]]};
    dig_col = no_key ? {1'b0, seg_blank} : {1'b0, hex_font[exp_col[3:0]]};
    dig_hi  = (exp_letter == 8'd0) ? {1'b0, seg_blank} : {1'b0, hex_font[exp_letter[7:4]]};
    dig_lo  = (exp_letter == 8'd0) ? {1'b0, seg_blank} : {1'b0, hex_font[exp_letter[3:0]]};
    return {no_key, exp_letter != 8'd0, exp_blue, dig_hi, dig_lo, dig_row, dig_col};
  endfunction

  // Keys 7 and 9 hold four letters, so later bases shift by one
  function automatic int set_size(input int digit);
    return (digit == 7 || digit == 9) ? 4 : 3;
  endfunction

  function automatic logic [7:0] letter_of(input int digit, input int tap);
    return 8'(8'h41 + 3 * (digit - 2) + ((digit > 7) ? 1 : 0) + tap);
  endfunction

  // Hold until the scan finds the key, settle, then release
  task automatic press_key(input int row, input int col);
    panel_check = 1'b0;  // Display moves to the new key
    key_req     = {4'b1000 >> row, 4'b1000 >> col};
    key_down    = 1'b1;
    @(posedge clk);
    #1;
    while (!col_hit) begin
      @(posedge clk);
      #1;
    end
    repeat (8) @(posedge clk);
    #1;
    exp_row     = row;
    exp_col     = col;
    exp_panel   = expect_panel();
    panel_check = 1'b1;  // Stays on through the release
    key_down    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
  endtask

  task automatic tap_digit(input int digit, input int count);
    int k;
    for (k = 1; k <= count; k++) begin
      exp_letter = letter_of(digit, (k - 1) % set_size(digit));  // Wraps at the set end
      press_key((digit - 1) / 3, (digit - 1) % 3);
    end
  endtask

  task automatic submit_letter(input logic in_progress);
    submit_pending = in_progress;
    if (in_progress)
      exp_blue = 1'b1;
    press_key(3, 0);
    submit_pending = 1'b0;
  endtask

  task automatic clear_letter();
    clear_pending = 1'b1;
    exp_letter    = 8'd0;
    exp_blue      = 1'b0;  // Blue drops with the letter
    press_key(3, 1);
    clear_pending = 1'b0;
  endtask

  initial begin
    nRst           = 1'b0;
    key_down       = 1'b0;
    key_req        = 8'd0;
    exp_letter     = 8'd0;
    exp_blue       = 1'b0;
    exp_row        = -1;
    exp_col        = -1;
    exp_panel      = 35'd0;
    panel_check    = 1'b0;
    submit_pending = 1'b0;
    clear_pending  = 1'b0;
    test_name      = "reset";
    void'($urandom(32'h3a45));
    repeat (16) @(posedge clk);
    #1 nRst = 1'b1;
    repeat (2) @(posedge clk);  // Red lights one clock out of reset
    #1;
    exp_panel   = expect_panel();
    panel_check = 1'b1;
    repeat (8) @(posedge clk);
    #1;

    for (int d = 2; d <= 9; d++) begin
      test_name = "single_tap";
      tap_digit(d, 1);
      submit_letter(1'b1);
      test_name = "clear";
      clear_letter();
    end
    submit_letter(1'b0);  // Nothing in progress, blue stays low

    for (int d = 7; d <= 8; d++) begin
      test_name = $sformatf("multi_tap_%0d", d);
      taps      = 1 + int'($urandom % 32'd9);
      tap_digit(d, taps);
      submit_letter(1'b1);
      if (d == 7)
        clear_letter();
    end

    // Submitted letter and blue survive keys without letters
    test_name = "invalid_keys";
    press_key(0, 0);  // Key 1
    press_key(1, 3);  // Letter column
    press_key(3, 2);  // Submit word

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* test/keypad_model.sv */
module keypad_model (
  input  logic [keypad_pkg::key_lines-1:0]      scan_col,  // Column driven by the scanner
  input  logic                                  key_down,  // A key is held
  input  logic [keypad_pkg::key_code_width-1:0] key_code,  // {row, col} of the held key
  output logic [keypad_pkg::key_lines-1:0]      read_row,
  output logic                                  col_hit    // Scan sits on the held key's column
);
  import keypad_pkg::*;

  // Switch closes only while its column is driven
  assign col_hit = key_down && ((scan_col & key_code[3:0]) != 4'd0);

  // Row line of the held key answers, all others stay low
  assign read_row = col_hit ? key_code[7:4] : 4'd0;

endmodule

/* design/keypad_text_top.sv */
module keypad_text_top (
  input  logic                             clk,
  input  logic                             nRst,
  input  logic [keypad_pkg::key_lines-1:0] read_row,
  output logic [keypad_pkg::key_lines-1:0] scan_col,
  output logic [7:0]                       ss0,
  output logic [7:0]                       ss1,
  output logic [7:0]                       ss2,
  output logic [7:0]                       ss3,
  output logic                             red,
  output logic                             green,
  output logic                             blue
);
  import keypad_pkg::*;

  // Scanner results
  logic                      key_strobe;
  logic [key_lines-1:0]      key_row;
  logic [key_lines-1:0]      key_col;
  logic [key_code_width-1:0] key_code;

  // Encoder and display results
  logic [7:0] letter;
  logic       letter_ready;
  logic [6:0] row_seg;
  logic [6:0] col_seg;

  keypad_scanner scanner (
    .clk        (clk),
    .nRst       (nRst),
    .read_row   (read_row),
    .scan_col   (scan_col),
    .key_strobe (key_strobe),
    .key_row    (key_row),
    .key_col    (key_col),
    .key_code   (key_code)
  );

  multitap_encoder encoder (
    .clk          (clk),
    .nRst         (nRst),
    .key_strobe   (key_strobe),
    .key_code     (key_code),
    .letter       (letter),
    .letter_ready (letter_ready)
  );

  key_position_display position (
    .key_row (key_row),
    .key_col (key_col),
    .row_seg (row_seg),
    .col_seg (col_seg)
  );

  panel_driver panel (
    .clk          (clk),
    .nRst         (nRst),
    .letter       (letter),
    .letter_ready (letter_ready),
    .row_seg      (row_seg),
    .col_seg      (col_seg),
    .ss0          (ss0),
    .ss1          (ss1),
    .ss2          (ss2),
    .ss3          (ss3),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

endmodule

/* design/panel_driver.sv */
module panel_driver (
  input  logic       clk,
  input  logic       nRst,
  input  logic [7:0] letter,
  input  logic       letter_ready,
  input  logic [6:0] row_seg,
  input  logic [6:0] col_seg,
  output logic [7:0] ss0,    // Column index
  output logic [7:0] ss1,    // Row index
  output logic [7:0] ss2,    // Letter, low hex nibble
  output logic [7:0] ss3,    // Letter, high hex nibble
  output logic       red,
  output logic       green,
  output logic       blue
);
  import keypad_pkg::*;

  logic letter_empty;

  // Hex digit patterns
  function automatic logic [6:0] hex_seg(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = seg_index_0;
      4'h1: seg = seg_index_1;
      4'h2: seg = seg_index_2;
      4'h3: seg = seg_index_3;
      4'h4: seg = 7'b1100110;
      4'h5: seg = 7'b1101101;
      4'h6: seg = 7'b1111101;
      4'h7: seg = 7'b0000111;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1100111;
      4'hA: seg = 7'b1110111;
      4'hB: seg = 7'b1111100;
      4'hC: seg = 7'b0111001;
      4'hD: seg = 7'b1011110;
      4'hE: seg = 7'b1111001;
      default: seg = 7'b1110001;  // F
    endcase
    return seg;
  endfunction

  assign letter_empty = (letter == 8'd0);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      ss0   <= {1'b0, seg_blank};
      ss1   <= {1'b0, seg_blank};
      ss2   <= {1'b0, seg_blank};
      ss3   <= {1'b0, seg_blank};
      red   <= 1'b0;
      green <= 1'b0;
      blue  <= 1'b0;
    end else begin
      ss0   <= {1'b0, col_seg};  // Decimal point off
      ss1   <= {1'b0, row_seg};
      ss2   <= {1'b0, letter_empty ? seg_blank : hex_seg(letter[3:0])};
      ss3   <= {1'b0, letter_empty ? seg_blank : hex_seg(letter[7:4])};
      red   <= (row_seg == seg_blank) && (col_seg == seg_blank);  // No key seen
      green <= !letter_empty;
      if (letter_empty)
        blue <= 1'b0;  // Cleared
      else if (letter_ready)
        blue <= 1'b1;  // Submitted, stays lit
    end
  end

endmodule

/* design/key_position_display.sv */
module key_position_display (
  input  logic [keypad_pkg::key_lines-1:0] key_row,
  input  logic [keypad_pkg::key_lines-1:0] key_col,
  output logic [6:0]                       row_seg,
  output logic [6:0]                       col_seg
);
  import keypad_pkg::*;

  // One-hot line to the digit of its index
  function automatic logic [6:0] index_seg(input logic [key_lines-1:0] lines);
    logic [6:0] seg;
    case (lines)
      4'b1000: seg = seg_index_0;
      4'b0100: seg = seg_index_1;
      4'b0010: seg = seg_index_2;
      4'b0001: seg = seg_index_3;
      default: seg = seg_blank;  // No key yet, or not one-hot
    endcase
    return seg;
  endfunction

  assign row_seg = index_seg(key_row);  // Row digit
  assign col_seg = index_seg(key_col);  // Column digit

endmodule

/* keypad/multitap_encoder.sv */
module multitap_encoder (
  input  logic                                  clk,
  input  logic                                  nRst,
  input  logic                                  key_strobe,
  input  logic [keypad_pkg::key_code_width-1:0] key_code,
  output logic [7:0]                            letter,        // Zero when no letter is shown
  output logic                                  letter_ready
);
  import keypad_pkg::*;

  logic [2:0]                state;
  logic [2:0]                state_next;
  logic [7:0]                letter_next;
  logic [7:0]                set_base;   // 0 for a key without letters
  logic                      set_long;
  logic [2:0]                set_size;
  logic [1:0]                tap;
  logic [1:0]                tap_next;
  logic                      key_ignored;
  logic                      in_letter;
  logic                      same_key;
  logic                      load_key;
  logic [key_code_width-1:0] prev_key;

  // Letter set of the pressed key
  always_comb begin
    set_base = 8'd0;
    set_long = 1'b0;
    case (key_code)
      {4'b1000, 4'b0100}: set_base = letter_base_2;
      {4'b1000, 4'b0010}: set_base = letter_base_3;
      {4'b0100, 4'b1000}: set_base = letter_base_4;
      {4'b0100, 4'b0100}: set_base = letter_base_5;
      {4'b0100, 4'b0010}: set_base = letter_base_6;
      {4'b0010, 4'b1000}: begin
        set_base = letter_base_7;
        set_long = 1'b1;
      end
      {4'b0010, 4'b0100}: set_base = letter_base_8;
      {4'b0010, 4'b0010}: begin
        set_base = letter_base_9;
        set_long = 1'b1;
      end
      default: set_base = 8'd0;  // Specials and multi-key codes
    endcase
  end

  assign set_size    = set_long ? set_size_long : set_size_long - 3'd1;
  assign key_ignored = (key_code == key_one) || (key_code[3:0] == col_invalid) ||
                       (key_code == key_submit_word);
  assign in_letter   = state[2];    // Any tap state
  assign tap         = state[1:0];
  assign same_key    = in_letter && (key_code == prev_key);

  // Advance on a repeat and wrap at the end of the set
  always_comb begin
    tap_next = 2'd0;
    if (same_key && (({1'b0, tap} + 3'd1) != set_size))
      tap_next = tap + 2'd1;
  end

  always_comb begin
    state_next  = state;
    letter_next = letter;
    load_key    = 1'b0;
    if (state == st_done)
      state_next = st_idle;  // Ready pulse lasts one cycle
    if (key_strobe && !key_ignored) begin
      if (key_code == key_clear) begin
        state_next  = st_idle;
        letter_next = 8'd0;
      end else if (key_code == key_submit_letter) begin
        if (in_letter)
          state_next = st_done;  // Letter stays shown after submit
      end else if (set_base != 8'd0) begin
        state_next  = {1'b1, tap_next};  // st_tap0 to st_tap3
        letter_next = set_base + {6'd0, tap_next};
        load_key    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state  <= st_idle;
      letter <= 8'd0;
    end else begin
      state  <= state_next;
      letter <= letter_next;
    end
  end

  // Digit key of the letter in progress
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      prev_key <= '0;
    else if (load_key)
      prev_key <= key_code;
  end

  assign letter_ready = (state == st_done);

endmodule

/* keypad/keypad_scanner.sv */
module keypad_scanner (
  input  logic                                  clk,
  input  logic                                  nRst,
  input  logic [keypad_pkg::key_lines-1:0]      read_row,  // Async from the board
  output logic [keypad_pkg::key_lines-1:0]      scan_col,
  output logic                                  key_strobe,
  output logic [keypad_pkg::key_lines-1:0]      key_row,
  output logic [keypad_pkg::key_lines-1:0]      key_col,
  output logic [keypad_pkg::key_code_width-1:0] key_code
);
  import keypad_pkg::*;

  logic [key_lines-1:0] scan_col_next;
  logic [key_lines-1:0] row_sync1;   // First sync stage
  logic [key_lines-1:0] row_sync2;   // Safe to use
  logic [key_lines-1:0] row_delay;   // Previous synced rows
  logic [key_lines-1:0] row_rise;
  logic [key_lines-1:0] row_hold;
  logic [key_lines-1:0] col_hold;

  // Column ring, stops on the column of a pressed key
  always_comb begin
    if (|read_row) begin
      scan_col_next = scan_col;  // Hold while a row answers
    end else begin
      case (scan_col)
        4'b1000: scan_col_next = 4'b0100;
        4'b0100: scan_col_next = 4'b0010;
        4'b0010: scan_col_next = 4'b0001;
        default: scan_col_next = 4'b1000;  // Out of reset, or wrap from column 3
      endcase
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      scan_col  <= '0;
      row_sync1 <= '0;
      row_sync2 <= '0;
      row_delay <= '0;
    end else begin
      scan_col  <= scan_col_next;
      row_sync1 <= read_row;
      row_sync2 <= row_sync1;
      row_delay <= row_sync2;
    end
  end

  // New press when a synced row bit goes high
  assign row_rise   = row_sync2 & ~row_delay;
  assign key_strobe = |row_rise;

  // Last key, kept for the position display
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_hold <= '0;
      col_hold <= '0;
    end else if (key_strobe) begin
      row_hold <= row_sync2;
      col_hold <= scan_col;  // Still held by the pressed row
    end
  end

  // Pass the fresh code through during the strobe itself
  assign key_row  = key_strobe ? row_sync2 : row_hold;
  assign key_col  = key_strobe ? scan_col : col_hold;
  assign key_code = {key_row, key_col};

endmodule

/* common/keypad_pkg.sv */
package keypad_pkg;

  // Keypad geometry
  localparam int key_lines      = 4;  // Rows and columns, one-hot, bit 3 is index 0
  localparam int key_code_width = 8;  // {row, col}, row in upper nibble

  // Special keys, {row, col}
  localparam logic [7:0] key_submit_letter = 8'b0001_1000;  // R3 C0, star
  localparam logic [7:0] key_clear         = 8'b0001_0100;  // R3 C1, zero
  localparam logic [7:0] key_submit_word   = 8'b0001_0010;  // R3 C2, hash
  localparam logic [7:0] key_one           = 8'b1000_1000;  // R0 C0, no letters

  // Letter column A-D, never a digit key
  localparam logic [3:0] col_invalid = 4'b0001;

  // First letter on each digit key
  localparam logic [7:0] letter_base_2 = 8'h41;  // A
  localparam logic [7:0] letter_base_3 = 8'h44;  // D
  localparam logic [7:0] letter_base_4 = 8'h47;  // G
  localparam logic [7:0] letter_base_5 = 8'h4A;  // J
  localparam logic [7:0] letter_base_6 = 8'h4D;  // M
  localparam logic [7:0] letter_base_7 = 8'h50;  // P, PQRS
  localparam logic [7:0] letter_base_8 = 8'h54;  // T
  localparam logic [7:0] letter_base_9 = 8'h57;  // W, WXYZ

  // Keys 7 and 9 carry four letters, the rest three
  localparam logic [2:0] set_size_long = 3'd4;

  // Multi-tap encoder states
  // Tap states have bit 2 set, tap index in the low bits
  localparam logic [2:0] st_idle = 3'b000;
  localparam logic [2:0] st_done = 3'b001;  // One cycle, drives letter_ready
  localparam logic [2:0] st_tap0 = 3'b100;
  localparam logic [2:0] st_tap1 = 3'b101;
  localparam logic [2:0] st_tap2 = 3'b110;
  localparam logic [2:0] st_tap3 = 3'b111;

  // Seven-segment patterns, active high, g in bit 6
  localparam logic [6:0] seg_index_0 = 7'b0111111;
  localparam logic [6:0] seg_index_1 = 7'b0000110;
  localparam logic [6:0] seg_index_2 = 7'b1011011;
  localparam logic [6:0] seg_index_3 = 7'b1001111;
  localparam logic [6:0] seg_blank   = 7'b0000000;  // All segments off

endpackage
